//--- build.f
design/cube_geom_pkg.sv
design/cube_cmd_pkg.sv
design/edge2en.sv
design/spi_byte_rx.sv
design/layer_ctl.sv
design/cube_frame_buf.sv
design/cube_top.sv
tb/cube_tb.sv

//--- design/cube_cmd_pkg.sv
// cube command package
// Command opcodes understood by the layer controller and the
// received SPI byte as handed from the receiver to the controller.

package cube_cmd_pkg;

    typedef enum logic [7:0] {
        CMD_ADDR_WR = 8'hCC, // write address lane.
        CMD_DATA_WR = 8'hDA  // write colour lanes.
    } cube_cmd_e;

    typedef struct packed {
        logic       dc;   // low for command.
        logic [7:0] data;
    } spi_byte_t;

endpackage

//--- design/cube_frame_buf.sv
// cube_frame_buf
// Eight 64x32 layer memories. Writes go to every enabled lane of one
// word in every enabled layer, with one synchronous read port.

`timescale 1ns/1ns

module cube_frame_buf (
    input  logic                                          clk_in,
    input  logic                                          rst_n_in,
    input  cube_geom_pkg::fb_wr_t                         fb_wr,
    input  logic                                          rd_en,
    input  logic [$clog2(cube_geom_pkg::NUM_LAYERS)-1:0]  rd_layer,
    input  logic [cube_geom_pkg::WORD_ADDR_W-1:0]         rd_addr,
    output cube_geom_pkg::cube_word_t                     rd_data
);

    logic [cube_geom_pkg::LANES*8-1:0] mem [cube_geom_pkg::NUM_LAYERS]
                                           [cube_geom_pkg::NUM_WORDS];

    always_ff @(posedge clk_in) begin
        for (int l = 0; l < cube_geom_pkg::NUM_LAYERS; l++) begin
            if (fb_wr.layer_we[l]) begin
                for (int b = 0; b < cube_geom_pkg::LANES; b++) begin
                    if (fb_wr.lane_en[b]) begin
                        mem[l][fb_wr.addr][b*8 +: 8] <= fb_wr.data;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= cube_geom_pkg::cube_word_t'(mem[rd_layer][rd_addr]);
        end
    end

endmodule

//--- design/cube_geom_pkg.sv
// cube geometry package
// Holds the size constants of the 8x8x8 LED cube frame store and the
// word and write-port types that the controller and frame buffer share.

package cube_geom_pkg;

    localparam int NUM_LAYERS  = 8;  // layers per cube.
    localparam int NUM_WORDS   = 64; // words per layer.
    localparam int WORD_ADDR_W = 6;  // word address width.
    localparam int LANES       = 4;  // byte lanes per word.

    // one frame buffer word, lane 3 down to lane 0.
    typedef struct packed {
        logic [7:0] sel; // address lane.
        logic [7:0] c0;  // first colour.
        logic [7:0] c1;
        logic [7:0] c2;
    } cube_word_t;

    // write port from the layer controller into the frame buffer.
    typedef struct packed {
        logic [NUM_LAYERS-1:0]  layer_we; // one per layer.
        logic [WORD_ADDR_W-1:0] addr;
        logic [LANES-1:0]       lane_en;  // sel, c0, c1, c2.
        logic [7:0]             data;
    } fb_wr_t;

endpackage

//--- design/cube_top.sv
// cube_top
// Receive and frame-store path of the LED cube controller. SPI bytes
// feed the layer controller, which writes the frame buffer. The frame
// buffer read port and the frame strobe leave the block.

`timescale 1ns/1ns

module cube_top (
    input  logic                                          clk_in,
    input  logic                                          rst_n_in,
    input  logic                                          spi_sclk,
    input  logic                                          spi_mosi,
    input  logic                                          spi_cs_n,
    input  logic                                          spi_dc,
    input  logic                                          rd_en,
    input  logic [$clog2(cube_geom_pkg::NUM_LAYERS)-1:0]  rd_layer,
    input  logic [cube_geom_pkg::WORD_ADDR_W-1:0]         rd_addr,
    output cube_geom_pkg::cube_word_t                     rd_data,
    output logic                                          frame_rdy
);

    logic                    byte_rdy;
    cube_cmd_pkg::spi_byte_t rx_byte;
    cube_geom_pkg::fb_wr_t   fb_wr;

    spi_byte_rx spi_rx_i (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .spi_dc   (spi_dc),
        .byte_rdy (byte_rdy),
        .rx_byte  (rx_byte)
    );

    layer_ctl layer_ctl_i (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .spi_cs_n  (spi_cs_n), // synchronized inside.
        .byte_rdy  (byte_rdy),
        .rx_byte   (rx_byte),
        .fb_wr     (fb_wr),
        .frame_rdy (frame_rdy)
    );

    cube_frame_buf frame_buf_i (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .fb_wr    (fb_wr),
        .rd_en    (rd_en),
        .rd_layer (rd_layer),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

//--- design/edge2en.sv
// edge2en
// Two-flop synchronizer for an asynchronous input. Gives the clean
// level plus single-cycle rising and falling strobes.

`timescale 1ns/1ns

module edge2en (
    input  logic clk_in,
    input  logic rst_n_in,
    input  logic edge_in,
    output logic level_out,
    output logic rising_out,
    output logic falling_out
);

    logic [2:0] sync_q;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            sync_q <= 3'b000;
        end else begin
            sync_q <= {sync_q[1:0], edge_in};
        end
    end

    assign level_out   = sync_q[1];
    assign rising_out  = sync_q[1] & ~sync_q[2]; // one cycle wide.
    assign falling_out = ~sync_q[1] & sync_q[2];

endmodule

//--- design/layer_ctl.sv
// layer_ctl
// Decodes address-write and data-write commands and sequences the
// frame buffer write enables, lanes and word address for each data byte.
// Pulses frame_rdy after the last colour byte of layer 0.

`timescale 1ns/1ns

module layer_ctl (
    input  logic                     clk_in,
    input  logic                     rst_n_in,
    input  logic                     spi_cs_n,
    input  logic                     byte_rdy,
    input  cube_cmd_pkg::spi_byte_t  rx_byte,
    output cube_geom_pkg::fb_wr_t    fb_wr,
    output logic                     frame_rdy
);

    logic                                  cs_fall;
    logic                                  frame_rst_n;
    logic                                  addr_en;
    logic [2:0]                            color_en;
    logic [cube_geom_pkg::NUM_LAYERS-1:0]  layer_en;
    logic [cube_geom_pkg::WORD_ADDR_W-1:0] wr_addr;
    logic                                  addr_done;
    logic                                  color_done;
    logic                                  layer_done;
    logic                                  data_byte;

    edge2en cs_sync_i (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .edge_in     (spi_cs_n),
        .level_out   (),
        .rising_out  (),
        .falling_out (cs_fall)
    );

    assign addr_done  = (wr_addr == cube_geom_pkg::WORD_ADDR_W'(cube_geom_pkg::NUM_WORDS - 1));
    assign color_done = color_en[0]; // c2 lane.
    assign layer_done = layer_en[0];
    assign data_byte  = byte_rdy & rx_byte.dc;

    // command bytes never write.
    assign fb_wr.layer_we = layer_en & {cube_geom_pkg::NUM_LAYERS{data_byte}};
    assign fb_wr.addr     = wr_addr;
    assign fb_wr.lane_en  = {addr_en, color_en};
    assign fb_wr.data     = rx_byte.data;

    // armed by cs_n fall, dropped after frame_rdy.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            frame_rst_n <= 1'b0;
        end else begin
            frame_rst_n <= ~frame_rdy & (cs_fall | frame_rst_n);
        end
    end

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            addr_en   <= 1'b0;
            color_en  <= 3'b000;
            layer_en  <= '0;
            wr_addr   <= '0;
            frame_rdy <= 1'b0;
        end else if (!frame_rst_n) begin
            addr_en   <= 1'b0;
            color_en  <= 3'b000;
            layer_en  <= '0;
            wr_addr   <= '0;
            frame_rdy <= 1'b0;
        end else begin
            if (byte_rdy && !rx_byte.dc) begin
                case (cube_cmd_pkg::cube_cmd_e'(rx_byte.data))
                    cube_cmd_pkg::CMD_ADDR_WR: begin
                        addr_en  <= 1'b1;
                        color_en <= 3'b000;
                        layer_en <= '1; // all layers at once.
                    end
                    cube_cmd_pkg::CMD_DATA_WR: begin
                        addr_en  <= 1'b0;
                        color_en <= 3'b100;
                        layer_en <= {1'b1, {(cube_geom_pkg::NUM_LAYERS-1){1'b0}}};
                    end
                    default: begin
                        addr_en  <= 1'b0;
                        color_en <= 3'b000;
                        layer_en <= '0;
                    end
                endcase
                wr_addr <= '0;
            end else if (data_byte) begin
                if (addr_en) begin
                    if (addr_done) begin
                        layer_en <= '0;
                    end
                    wr_addr <= wr_addr + 1'b1;
                end else begin
                    color_en <= {color_en[0], color_en[2:1]}; // c0, c1, c2.
                    if (color_done) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (addr_done) begin
                            layer_en <= layer_en >> 1; // next layer down.
                        end
                    end
                end
            end
            frame_rdy <= data_byte & addr_done & color_done & layer_done;
        end
    end

endmodule

//--- design/spi_byte_rx.sv
// spi_byte_rx
// SPI mode-0 slave receiver. Assembles MSB-first bytes on the
// synchronized sclk rising strobe and tags each byte with dc.

`timescale 1ns/1ns

module spi_byte_rx (
    input  logic                    clk_in,
    input  logic                    rst_n_in,
    input  logic                    spi_sclk,
    input  logic                    spi_mosi,
    input  logic                    spi_cs_n,
    input  logic                    spi_dc,
    output logic                    byte_rdy,
    output cube_cmd_pkg::spi_byte_t rx_byte
);

    logic       sclk_rise;
    logic       mosi_lvl;
    logic       cs_lvl;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;

    edge2en sclk_sync_i (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .edge_in     (spi_sclk),
        .level_out   (),
        .rising_out  (sclk_rise),
        .falling_out ()
    );

    edge2en mosi_sync_i (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .edge_in     (spi_mosi),
        .level_out   (mosi_lvl),
        .rising_out  (),
        .falling_out ()
    );

    edge2en cs_sync_i (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .edge_in     (spi_cs_n),
        .level_out   (cs_lvl),
        .rising_out  (),
        .falling_out ()
    );

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            bit_cnt  <= 3'd0;
            byte_rdy <= 1'b0;
        end else begin
            byte_rdy <= 1'b0;
            if (cs_lvl) begin
                bit_cnt <= 3'd0; // partial byte dropped.
            end else if (sclk_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                byte_rdy <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!cs_lvl && sclk_rise) begin
            shift_q <= {shift_q[5:0], mosi_lvl};
            if (bit_cnt == 3'd7) begin
                rx_byte.data <= {shift_q, mosi_lvl};
                rx_byte.dc   <= spi_dc; // dc held steady across the byte.
            end
        end
    end

endmodule

//--- tb/cube_tb.sv
// cube_tb
// Testbench for the LED cube receive path. Sends SPI frames, keeps a
// shadow copy of the frame store and reads every word back to compare.

`timescale 1ns/1ns

module cube_tb;

    localparam int     CLK_NS      = 8;
    localparam int     HALF_CYC    = 4; // sclk half period in clk cycles.
    localparam int     COLOR_BYTES = cube_geom_pkg::NUM_LAYERS * cube_geom_pkg::NUM_WORDS * 3;
    localparam int     TOTAL_BYTES = 65 + (COLOR_BYTES + 1) + 11 + 101 + 51;
    localparam longint WATCHDOG_NS = longint'(TOTAL_BYTES) * 8 * 8 * CLK_NS + 100000;

    logic                      clk_in;
    logic                      rst_n_in;
    logic                      spi_sclk;
    logic                      spi_mosi;
    logic                      spi_cs_n;
    logic                      spi_dc;
    logic                      rd_en;
    logic [2:0]                rd_layer;
    logic [5:0]                rd_addr;
    cube_geom_pkg::cube_word_t rd_data;
    logic                      frame_rdy;

    cube_geom_pkg::cube_word_t shadow [cube_geom_pkg::NUM_LAYERS][cube_geom_pkg::NUM_WORDS];
    logic [7:0]                payload [COLOR_BYTES];
    int                        seed = 40;
    int                        mode_q = 0; // 0 idle, 1 address, 2 colour.
    int                        layer_q = 7;
    int                        word_q = 0;
    int                        lane_q = 0;
    int                        rdy_count = 0;
    int                        early_count = 0;
    logic                      final_sent = 1'b0;

    cube_top dut_i (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .spi_sclk  (spi_sclk),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .spi_dc    (spi_dc),
        .rd_en     (rd_en),
        .rd_layer  (rd_layer),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .frame_rdy (frame_rdy)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_NS / 2) clk_in = ~clk_in;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error %s expected %08h actual %08h", name, expected, actual));
        end
    endtask

    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    // shadow model of the controller's lane and layer sequencing.
    task automatic apply_byte(input logic dc, input logic [7:0] b);
        if (!dc) begin
            word_q  = 0;
            lane_q  = 0;
            layer_q = 7;
            if (b == cube_cmd_pkg::CMD_ADDR_WR) mode_q = 1;
            else if (b == cube_cmd_pkg::CMD_DATA_WR) mode_q = 2;
            else mode_q = 0;
        end else if (mode_q == 1) begin
            for (int l = 0; l < cube_geom_pkg::NUM_LAYERS; l++) begin
                shadow[l][word_q].sel = b;
            end
            if (word_q == cube_geom_pkg::NUM_WORDS - 1) mode_q = 0; // enables drop.
            word_q++;
        end else if (mode_q == 2) begin
            case (lane_q)
                0: shadow[layer_q][word_q].c0 = b;
                1: shadow[layer_q][word_q].c1 = b;
                default: shadow[layer_q][word_q].c2 = b;
            endcase
            if (lane_q < 2) begin
                lane_q++;
            end else begin
                lane_q = 0;
                if (word_q < cube_geom_pkg::NUM_WORDS - 1) begin
                    word_q++;
                end else begin
                    word_q = 0;
                    if (layer_q == 0) mode_q = 0;
                    else layer_q--;
                end
            end
        end
    endtask

    function automatic cube_geom_pkg::cube_word_t ref_word(input int layer, input int word);
        return shadow[layer][word];
    endfunction

    task automatic send_byte(input logic dc, input logic [7:0] b);
        spi_dc = dc;
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = b[i];
            spi_sclk = 1'b0;
            repeat (HALF_CYC) step();
            spi_sclk = 1'b1; // mode 0, slave samples here.
            repeat (HALF_CYC) step();
        end
        spi_sclk = 1'b0;
        apply_byte(dc, b);
    endtask

    task automatic fill_payload(input int n);
        for (int i = 0; i < n; i++) begin
            payload[i] = 8'($random(seed));
        end
    endtask

    task automatic send_frame(input logic [7:0] cmd, input int count);
        final_sent = 1'b0;
        spi_cs_n = 1'b0;
        repeat (4) step();
        send_byte(1'b0, cmd);
        for (int i = 0; i < count; i++) begin
            if (i == count - 1) final_sent = 1'b1;
            send_byte(1'b1, payload[i]);
        end
        repeat (4) step();
        spi_cs_n = 1'b1;
        repeat (8) step();
    endtask

    task automatic read_word(input int layer, input int word,
                             output cube_geom_pkg::cube_word_t data);
        rd_en    = 1'b1;
        rd_layer = 3'(layer);
        rd_addr  = 6'(word);
        step();
        rd_en = 1'b0;
        data  = rd_data;
    endtask

    task automatic check_all(input string test);
        cube_geom_pkg::cube_word_t got;
        for (int l = 0; l < cube_geom_pkg::NUM_LAYERS; l++) begin
            for (int w = 0; w < cube_geom_pkg::NUM_WORDS; w++) begin
                read_word(l, w, got);
                check_value($sformatf("%s layer %0d word %0d", test, l, w), ref_word(l, w), got);
            end
        end
    endtask

    task automatic wait_frame_rdy();
        int n;
        n = 0;
        while (rdy_count == 0 && n < 32) begin
            step();
            n++;
        end
        if (rdy_count == 0) fail_run("frame_rdy never pulsed after the final colour byte");
    endtask

    // frame strobe counter, sampled away from the active edge.
    always @(negedge clk_in) begin
        if (frame_rdy === 1'b1) begin
            rdy_count++;
            if (!final_sent) early_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout: the test sequence did not finish in the allowed time");
    end

    initial begin
        rst_n_in = 1'b0;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        spi_cs_n = 1'b1;
        spi_dc   = 1'b0;
        rd_en    = 1'b0;
        rd_layer = 3'd0;
        rd_addr  = 6'd0;
        repeat (5) @(posedge clk_in);
        #1;
        rst_n_in = 1'b1;
        repeat (4) step();
        check_value("reset frame_rdy", 32'd0, frame_rdy);
        check_value("reset frame_rdy count", 32'd0, rdy_count);
        check_value("reset rd_data", 32'd0, rd_data);

        fill_payload(64);
        send_frame(cube_cmd_pkg::CMD_ADDR_WR, 64);
        check_all("address frame");
        check_value("address frame frame_rdy count", 32'd0, rdy_count);

        fill_payload(COLOR_BYTES);
        send_frame(cube_cmd_pkg::CMD_DATA_WR, COLOR_BYTES);
        wait_frame_rdy();
        check_value("colour frame frame_rdy count", 32'd1, rdy_count);
        check_value("colour frame early frame_rdy", 32'd0, early_count);
        check_all("colour frame");

        fill_payload(100);
        send_frame(cube_cmd_pkg::CMD_DATA_WR, 100);
        fill_payload(50);
        send_frame(cube_cmd_pkg::CMD_DATA_WR, 50);
        check_all("restart");

        // colour sequence still live here, so the command must stop it.
        fill_payload(10);
        send_frame(8'h5A, 10); // not an opcode.
        check_all("unknown command");
        check_value("total frame_rdy count", 32'd1, rdy_count);

        $display("Simulation passed");
        $finish;
    end

endmodule
